/* build.f */
+incdir+verilog
verilog/bowl_pkg.sv
verilog/vga_timing.sv
verilog/render_ctrl.sv
verilog/pixel_shader.sv
verilog/frame_buffer.sv
verilog/video_out_stage.sv
verilog/bowl_display_top.sv
verification/bowl_display_assert.sv
verification/bowl_display_tb.sv

/* Makefile */
TOP := bowl_display_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f verilog/*.sv verilog/*.svh verification/*.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* verification/bowl_display_tb.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module bowl_display_tb;

  import bowl_pkg::*;

  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int PIXELS       = `H_ACTIVE * `V_ACTIVE;
  localparam int SCENES       = 8; // Empty lane, three pin sets, three balls, one latch
  localparam int WATCHDOG_NS  = (SCENES * 3 + 12) * FRAME_CYCLES * 4; // About 3 frames a scene

  logic        clk_pixel;
  logic        rst_n;
  scene_t      scene;
  logic        scene_valid;
  video_sync_t vga_sync;
  color_t      vga_rgb;
  logic        frame_done;
  color_t      captured [PIXELS];

  bowl_display_top u_bowl_display_top (
    .clk_pixel   (clk_pixel),
    .rst_n       (rst_n),
    .scene       (scene),
    .scene_valid (scene_valid),
    .vga_sync    (vga_sync),
    .vga_rgb     (vga_rgb),
    .frame_done  (frame_done)
  );

  always #2 clk_pixel = ~clk_pixel;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_color(input string name, input color_t exp, input color_t act);
    if (act !== exp) begin
      report_failure($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic compare_sync(input string name, input video_sync_t exp, input video_sync_t act);
    if (act !== exp) begin
      report_failure($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("error at %0t: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  // Outputs are sampled on the falling edge
  task automatic step(input string what, inout int budget);
    @(negedge clk_pixel);
    budget--;
    if (budget <= 0) report_failure($sformatf("Timed out waiting for %s", what));
  endtask

  task automatic wait_frame_done();
    int budget;
    budget = 2 * FRAME_CYCLES;
    @(negedge clk_pixel);
    while (frame_done !== 1'b1) step("frame_done", budget);
  endtask

  task automatic wait_frame_start(inout int budget);
    @(negedge clk_pixel);
    while (vga_sync.vsync !== 1'b1) step("vsync high", budget);
    while (vga_sync.vsync !== 1'b0) step("vsync low", budget);
    while (vga_sync.de !== 1'b1) step("first de of the frame", budget);
  endtask

  task automatic capture_frame();
    int budget;
    int n;
    budget = 3 * FRAME_CYCLES;
    wait_frame_start(budget);
    n = 0;
    while (n < PIXELS) begin
      if (vga_sync.de === 1'b1) begin
        captured[n] = vga_rgb; // Raster order over the active area
        n++;
      end
      step("captured frame", budget);
    end
  endtask

  // Ball over standing pin over lane, positions region-relative
  task automatic model_pixel(input scene_t s, input int x, input int y, output color_t c);
    int  px;
    int  i;
    bit  pin_hit;
    pin_hit = 1'b0;
    for (i = 0; i < `NUM_PINS; i++) begin
      px = `PIN_ROW_Y + `PIN_PITCH * i;
      if (s.pins_up[i] && x >= px && x < px + `PIN_SIZE &&
          y >= `PIN_ROW_Y && y < `PIN_ROW_Y + `PIN_SIZE) pin_hit = 1'b1;
    end
    if (x >= int'(s.ball_x) && x < int'(s.ball_x) + `BALL_SIZE &&
        y >= int'(s.ball_y) && y < int'(s.ball_y) + `BALL_SIZE) c = color_t'(`COLOR_BALL);
    else if (pin_hit) c = color_t'(`COLOR_PIN);
    else c = color_t'(`COLOR_LANE);
  endtask

  task automatic check_frame(input scene_t s, input string label);
    color_t exp;
    bit     in_region;
    for (int v = 0; v < `V_ACTIVE; v++) begin
      for (int h = 0; h < `H_ACTIVE; h++) begin
        in_region = h >= `REGION_X0 && h < `REGION_X0 + `REGION_W &&
                    v >= `REGION_Y0 && v < `REGION_Y0 + `REGION_H;
        exp = '0; // Black border
        if (in_region) model_pixel(s, h - `REGION_X0, v - `REGION_Y0, exp);
        compare_color($sformatf("vga_rgb %s x=%0d y=%0d", label, h, v), exp,
                      captured[v * `H_ACTIVE + h]);
      end
    end
  endtask

  function automatic scene_t make_scene(input int bx, input int by, input logic [9:0] pins);
    scene_t s;
    s.ball_x  = 7'(bx);
    s.ball_y  = 7'(by);
    s.pins_up = pins;
    return s;
  endfunction

  task automatic load_scene(input scene_t s);
    @(posedge clk_pixel);
    scene       <= s;
    scene_valid <= 1'b1;
    @(posedge clk_pixel);
    scene_valid <= 1'b0;
  endtask

  // Two passes guarantee the buffer holds only the new scene
  task automatic show_scene(input scene_t s, input string label);
    load_scene(s);
    wait_frame_done();
    wait_frame_done();
    capture_frame();
    check_frame(s, label);
  endtask

  task automatic reset_outputs();
    int budget;
    int cycles;
    repeat (2) begin
      @(negedge clk_pixel);
      compare_sync("vga_sync in reset", '0, vga_sync);
      compare_color("vga_rgb in reset", '0, vga_rgb);
      compare_bit("frame_done in reset", 1'b0, frame_done);
    end
    @(posedge clk_pixel);
    rst_n <= 1'b1;
    @(negedge clk_pixel);
    budget = 2 * FRAME_CYCLES;
    cycles = 0;
    while (frame_done !== 1'b1) begin
      if (cycles < `REGION_Y0 * `H_TOTAL) compare_color("vga_rgb above region", '0, vga_rgb);
      cycles++;
      step("first frame_done", budget);
    end
    // New frame, full sweep, last write, then the done pulse
    compare_count("cycles to first frame_done", `BUF_DEPTH + 2, cycles);
    step("end of frame_done", budget);
    compare_bit("frame_done after pulse", 1'b0, frame_done);
  endtask

  task automatic sync_timing();
    int budget;
    int len;
    int vs_len;
    int run;
    int lines;
    bit seen_low;
    budget = 3 * FRAME_CYCLES;
    while (vga_sync.hsync !== 1'b1) step("hsync rise", budget);
    len = 0;
    while (vga_sync.hsync === 1'b1) begin
      len++;
      step("hsync fall", budget);
    end
    compare_count("hsync width", `H_SYNC, len);
    while (vga_sync.hsync !== 1'b1) begin
      len++;
      step("next hsync rise", budget);
    end
    compare_count("hsync period", `H_TOTAL, len);
    while (vga_sync.vsync !== 1'b1) step("vsync rise", budget);
    len      = 0;
    vs_len   = 0;
    run      = 0;
    lines    = 0;
    seen_low = 1'b0;
    while (!(seen_low && vga_sync.vsync === 1'b1)) begin
      if (vga_sync.vsync !== 1'b1) seen_low = 1'b1;
      else if (!seen_low) vs_len++;
      if (vga_sync.de === 1'b1) begin
        run++;
      end else if (run != 0) begin
        compare_count("de cycles per line", `H_ACTIVE, run);
        lines++;
        run = 0;
      end
      len++;
      step("vsync period", budget);
    end
    compare_count("vsync width", `V_SYNC * `H_TOTAL, vs_len);
    compare_count("vsync period", FRAME_CYCLES, len);
    compare_count("lines with de", `V_ACTIVE, lines);
  endtask

  task automatic empty_lane();
    show_scene(make_scene(60, 20, 10'h000), "empty lane"); // Ball fully right of the region
  endtask

  task automatic random_pins();
    logic [9:0] pins;
    repeat (3) begin
      pins = 10'($urandom());
      show_scene(make_scene(60, 40, pins), $sformatf("pins %h", pins));
    end
  endtask

  task automatic ball_positions();
    show_scene(make_scene(15, 3, 10'h3FF), "ball over pin 3");
    show_scene(make_scene(46, 20, 10'h3FF), "ball clipped at right edge");
    show_scene(make_scene(30, 0, 10'h3FF), "ball on top edge");
  endtask

  task automatic scene_latching();
    scene_t new_s;
    int     budget;
    new_s  = make_scene(40, 12, 10'h2AA);
    budget = 2 * FRAME_CYCLES;
    wait_frame_start(budget); // Sweep of this frame is under way
    repeat (100) @(negedge clk_pixel);
    load_scene(new_s);
    wait_frame_done();
    wait_frame_done();
    capture_frame();
    check_frame(new_s, "latched scene");
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_failure($sformatf("Watchdog expired after %0d ns, the tests did not finish",
                             WATCHDOG_NS));
  end

  // Bound checker failures end the run as well
  always @(negedge clk_pixel) begin
    if (u_bowl_display_top.u_bowl_display_assert.failures != 0) begin
      report_failure("A concurrent assertion on the display failed");
    end
  end

  initial begin
    clk_pixel   = 1'b0;
    rst_n       = 1'b0;
    scene       = '0;
    scene_valid = 1'b0;
    void'($urandom(39));
    reset_outputs();
    sync_timing();
    empty_lane();
    random_pins();
    ball_positions();
    scene_latching();
    if (u_bowl_display_top.u_bowl_display_assert.failures == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_failure("A concurrent assertion on the display failed");
    end
  end

endmodule

/* verification/bowl_display_assert.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module bowl_display_assert (
  input logic                  clk_pixel,
  input logic                  rst_n,
  input bowl_pkg::video_sync_t vga_sync,
  input bowl_pkg::color_t      vga_rgb,
  input logic                  frame_done,
  input bowl_pkg::buf_write_t  buf_wr
);

  int failures = 0;

  frame_done_pulse: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    frame_done |=> !frame_done)
    else begin
      $error("frame_done high on two consecutive cycles");
      failures++;
    end

  no_de_in_sync: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    vga_sync.de |-> !(vga_sync.hsync || vga_sync.vsync))
    else begin
      $error("de high during a sync pulse");
      failures++;
    end

  wr_addr_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    buf_wr.wr_en |-> (buf_wr.addr < 12'(`BUF_DEPTH)))
    else begin
      $error("frame buffer write address %0d out of range", buf_wr.addr);
      failures++;
    end

  // From the second reset edge on, once the async reset has reached every flop
  quiet_in_reset: assert property (@(posedge clk_pixel)
    !rst_n |=> (rst_n || (vga_sync == '0 && vga_rgb == '0 && !frame_done)))
    else begin
      $error("outputs not low during reset");
      failures++;
    end

endmodule

bind bowl_display_top bowl_display_assert u_bowl_display_assert (
  .clk_pixel  (clk_pixel),
  .rst_n      (rst_n),
  .vga_sync   (vga_sync),
  .vga_rgb    (vga_rgb),
  .frame_done (frame_done),
  .buf_wr     (buf_wr)
);

/* verilog/bowl_display_top.sv */
`timescale 1ns/1ps

module bowl_display_top (
  input  logic                  clk_pixel,
  input  logic                  rst_n,
  input  bowl_pkg::scene_t      scene,
  input  logic                  scene_valid,
  output bowl_pkg::video_sync_t vga_sync,
  output bowl_pkg::color_t      vga_rgb,
  output logic                  frame_done
);

  import bowl_pkg::*;

  pixel_pos_t  scan_pos;
  video_sync_t raw_sync;
  logic        new_frame;
  pixel_pos_t  region_pos;
  logic        pos_valid;
  scene_t      active_scene;
  buf_write_t  buf_wr;
  logic [11:0] rd_addr;
  color_t      rd_data;

  vga_timing u_vga_timing (
    .clk_pixel (clk_pixel),
    .rst_n     (rst_n),
    .scan_pos  (scan_pos),
    .raw_sync  (raw_sync),
    .new_frame (new_frame)
  );

  render_ctrl u_render_ctrl (
    .clk_pixel    (clk_pixel),
    .rst_n        (rst_n),
    .new_frame    (new_frame),
    .scene        (scene),
    .scene_valid  (scene_valid),
    .region_pos   (region_pos),
    .pos_valid    (pos_valid),
    .active_scene (active_scene),
    .frame_done   (frame_done)
  );

  pixel_shader u_pixel_shader (
    .clk_pixel    (clk_pixel),
    .rst_n        (rst_n),
    .region_pos   (region_pos),
    .pos_valid    (pos_valid),
    .active_scene (active_scene),
    .buf_wr       (buf_wr)
  );

  frame_buffer u_frame_buffer (
    .clk_pixel (clk_pixel),
    .buf_wr    (buf_wr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  video_out_stage u_video_out_stage (
    .clk_pixel (clk_pixel),
    .rst_n     (rst_n),
    .scan_pos  (scan_pos),
    .raw_sync  (raw_sync),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .vga_sync  (vga_sync),
    .vga_rgb   (vga_rgb)
  );

endmodule

/* verilog/video_out_stage.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module video_out_stage (
  input  logic                  clk_pixel,
  input  logic                  rst_n,
  input  bowl_pkg::pixel_pos_t  scan_pos,
  input  bowl_pkg::video_sync_t raw_sync,
  output logic [11:0]           rd_addr,
  input  bowl_pkg::color_t      rd_data,
  output bowl_pkg::video_sync_t vga_sync,
  output bowl_pkg::color_t      vga_rgb
);

  import bowl_pkg::*;

  localparam logic [6:0] X0 = 7'(`REGION_X0);
  localparam logic [6:0] X1 = 7'(`REGION_X0 + `REGION_W);
  localparam logic [6:0] Y0 = 7'(`REGION_Y0);
  localparam logic [6:0] Y1 = 7'(`REGION_Y0 + `REGION_H);

  logic                             in_region;
  logic [11:0]                      rel_x;
  logic [11:0]                      rel_y;
  video_sync_t [`READ_LATENCY-1:0]  sync_pipe;
  logic [`READ_LATENCY-1:0]         region_pipe;

  assign in_region = (scan_pos.hcount >= X0) && (scan_pos.hcount < X1) &&
                     (scan_pos.vcount >= Y0) && (scan_pos.vcount < Y1);

  assign rel_x   = {5'd0, scan_pos.hcount - X0};
  assign rel_y   = {5'd0, scan_pos.vcount - Y0};
  assign rd_addr = in_region ? rel_y * 12'(`REGION_W) + rel_x : 12'd0; // Park at 0 outside

  // Match the buffer read latency
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      sync_pipe   <= '0;
      region_pipe <= '0;
    end else begin
      sync_pipe   <= {sync_pipe[`READ_LATENCY-2:0], raw_sync};
      region_pipe <= {region_pipe[`READ_LATENCY-2:0], in_region};
    end
  end

  assign vga_sync = sync_pipe[`READ_LATENCY-1];
  assign vga_rgb  = (vga_sync.de && region_pipe[`READ_LATENCY-1]) ? rd_data : '0; // Black border

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module frame_buffer (
  input  logic                 clk_pixel,
  input  bowl_pkg::buf_write_t buf_wr,
  input  logic [11:0]          rd_addr,
  output bowl_pkg::color_t     rd_data
);

  import bowl_pkg::*;

  color_t mem [0:`BUF_DEPTH-1];
  color_t rd_q; // RAM output latch, rd_data is the output register

  // Write port from the shader
  always_ff @(posedge clk_pixel) begin
    if (buf_wr.wr_en) begin
      mem[buf_wr.addr] <= buf_wr.data;
    end
  end

  // Read first, two register stages as in high-performance block RAM
  always_ff @(posedge clk_pixel) begin
    rd_q    <= mem[rd_addr];
    rd_data <= rd_q;
  end

endmodule

/* verilog/pixel_shader.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module pixel_shader (
  input  logic                 clk_pixel,
  input  logic                 rst_n,
  input  bowl_pkg::pixel_pos_t region_pos,
  input  logic                 pos_valid,
  input  bowl_pkg::scene_t     active_scene,
  output bowl_pkg::buf_write_t buf_wr
);

  import bowl_pkg::*;

  localparam logic [6:0] PIN_Y0 = 7'(`PIN_ROW_Y);
  localparam logic [6:0] PIN_Y1 = 7'(`PIN_ROW_Y + `PIN_SIZE);

  logic [7:0]           ball_x_end;
  logic [7:0]           ball_y_end;
  logic                 ball_hit;
  logic                 pin_row;
  logic [`NUM_PINS-1:0] pin_cover;
  color_t               pix_color;
  logic [11:0]          pix_addr;
  logic                 wr_en_q;
  logic [11:0]          addr_q;
  color_t               data_q;

  // One bit wider so a ball near the edge does not wrap
  assign ball_x_end = {1'b0, active_scene.ball_x} + 8'(`BALL_SIZE);
  assign ball_y_end = {1'b0, active_scene.ball_y} + 8'(`BALL_SIZE);
  assign ball_hit   = (region_pos.hcount >= active_scene.ball_x) &&
                      ({1'b0, region_pos.hcount} < ball_x_end) &&
                      (region_pos.vcount >= active_scene.ball_y) &&
                      ({1'b0, region_pos.vcount} < ball_y_end);

  assign pin_row = (region_pos.vcount >= PIN_Y0) && (region_pos.vcount < PIN_Y1);

  // Pin row starts at the same offset in x as in y
  for (genvar i = 0; i < `NUM_PINS; i++) begin : g_pin
    localparam logic [6:0] PX0 = 7'(`PIN_ROW_Y + `PIN_PITCH * i);
    assign pin_cover[i] = active_scene.pins_up[i] && (region_pos.hcount >= PX0) &&
                          (region_pos.hcount < PX0 + 7'(`PIN_SIZE));
  end

  always_comb begin
    if (ball_hit) begin
      pix_color = color_t'(`COLOR_BALL);
    end else if (pin_row && |pin_cover) begin
      pix_color = color_t'(`COLOR_PIN);
    end else begin
      pix_color = color_t'(`COLOR_LANE);
    end
  end

  assign pix_addr = 12'(region_pos.vcount) * 12'(`REGION_W) + 12'(region_pos.hcount); // Row major

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= pos_valid;
    end
  end

  always_ff @(posedge clk_pixel) begin
    addr_q <= pix_addr;
    data_q <= pix_color;
  end

  assign buf_wr.wr_en = wr_en_q;
  assign buf_wr.addr  = addr_q;
  assign buf_wr.data  = data_q;

endmodule

/* verilog/render_ctrl.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module render_ctrl (
  input  logic                 clk_pixel,
  input  logic                 rst_n,
  input  logic                 new_frame,
  input  bowl_pkg::scene_t     scene,
  input  logic                 scene_valid,
  output bowl_pkg::pixel_pos_t region_pos,
  output logic                 pos_valid,
  output bowl_pkg::scene_t     active_scene,
  output logic                 frame_done
);

  import bowl_pkg::*;

  localparam logic [6:0] X_LAST = 7'(`REGION_W - 1);
  localparam logic [6:0] Y_LAST = 7'(`REGION_H - 1);

  render_state_e state;
  scene_t        pending_scene;
  logic          row_last;
  logic          sweep_last;

  assign row_last   = (region_pos.hcount == X_LAST);
  assign sweep_last = row_last && (region_pos.vcount == Y_LAST);
  assign pos_valid  = (state == SWEEP);

  // Pending scene only reaches the shader between passes
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      pending_scene <= '0;
      active_scene  <= '0;
    end else begin
      if (scene_valid) begin
        pending_scene <= scene;
      end
      if (new_frame && state == IDLE) begin
        active_scene <= pending_scene;
      end
    end
  end

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      region_pos <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= (state == FINISH); // Shader write of last pixel lands in FINISH
      case (state)
        IDLE: begin
          if (new_frame) begin
            state      <= SWEEP;
            region_pos <= '0;
          end
        end
        SWEEP: begin
          if (sweep_last) begin
            state <= FINISH;
          end else if (row_last) begin
            region_pos.hcount <= '0;
            region_pos.vcount <= region_pos.vcount + 7'd1;
          end else begin
            region_pos.hcount <= region_pos.hcount + 7'd1;
          end
        end
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/vga_timing.sv */
`timescale 1ns/1ps
`include "bowl_macros.svh"

module vga_timing (
  input  logic                  clk_pixel,
  input  logic                  rst_n,
  output bowl_pkg::pixel_pos_t  scan_pos,
  output bowl_pkg::video_sync_t raw_sync,
  output logic                  new_frame
);

  import bowl_pkg::*;

  localparam logic [6:0] H_LAST   = 7'(`H_TOTAL - 1);
  localparam logic [6:0] V_LAST   = 7'(`V_TOTAL - 1);
  localparam logic [6:0] H_ACT    = 7'(`H_ACTIVE);
  localparam logic [6:0] V_ACT    = 7'(`V_ACTIVE);
  localparam logic [6:0] HS_START = 7'(`H_ACTIVE + `H_FP);
  localparam logic [6:0] HS_END   = 7'(`H_ACTIVE + `H_FP + `H_SYNC);
  localparam logic [6:0] VS_START = 7'(`V_ACTIVE + `V_FP);
  localparam logic [6:0] VS_END   = 7'(`V_ACTIVE + `V_FP + `V_SYNC);

  pixel_pos_t cnt;

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (cnt.hcount == H_LAST) begin
      cnt.hcount <= '0; // End of line
      cnt.vcount <= (cnt.vcount == V_LAST) ? 7'd0 : cnt.vcount + 7'd1;
    end else begin
      cnt.hcount <= cnt.hcount + 7'd1;
    end
  end

  assign scan_pos = cnt;

  assign raw_sync.hsync = (cnt.hcount >= HS_START) && (cnt.hcount < HS_END);
  assign raw_sync.vsync = (cnt.vcount >= VS_START) && (cnt.vcount < VS_END); // Whole lines
  assign raw_sync.de    = (cnt.hcount < H_ACT) && (cnt.vcount < V_ACT);

  // Kicks off one render pass per frame
  assign new_frame = (cnt == '0);

endmodule

/* verilog/bowl_pkg.sv */
package bowl_pkg;

  // One 12-bit pixel
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } color_t;

  typedef struct packed {
    logic [6:0] hcount;
    logic [6:0] vcount;
  } pixel_pos_t;

  // Ball position is region-relative, pins_up[i] set when pin i stands
  typedef struct packed {
    logic [6:0] ball_x;
    logic [6:0] ball_y;
    logic [9:0] pins_up;
  } scene_t;

  // All active high
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } video_sync_t;

  typedef struct packed {
    logic       wr_en;
    logic [11:0] addr;
    color_t     data;
  } buf_write_t;

  typedef enum logic [1:0] {
    IDLE,
    SWEEP,
    FINISH
  } render_state_e;

endpackage

/* verilog/bowl_macros.svh */
`ifndef BOWL_MACROS_SVH
`define BOWL_MACROS_SVH

// Scaled-down VGA timing, in pixel clocks and lines
`define H_ACTIVE 80
`define H_FP 4
`define H_SYNC 8
`define H_BP 8
`define H_TOTAL (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)
`define V_ACTIVE 60
`define V_FP 2
`define V_SYNC 2
`define V_BP 6
`define V_TOTAL (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// Lane region on screen, also the frame buffer footprint
`define REGION_X0 16
`define REGION_Y0 8
`define REGION_W 48
`define REGION_H 48
`define BUF_DEPTH (`REGION_W * `REGION_H)

`define BALL_SIZE 4
`define PIN_SIZE 2
`define PIN_ROW_Y 4
`define PIN_PITCH 4
`define NUM_PINS 10

`define COLOR_BALL 12'hF00
`define COLOR_PIN 12'hFFF
`define COLOR_LANE 12'h963

`define READ_LATENCY 2

`endif
